/* include/zx_defines.svh */
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// port map
//////////////////////////////////////////////////////////////////////

// low byte shared by all extended ports
`define ZX_PORT_XT_LO   8'hAF

// high bytes of the extended ports
`define ZX_HI_SYSCONF   8'h20
`define ZX_HI_MEMCONF   8'h21
`define ZX_HI_BORDER    8'h0F

// window 0 page register, windows 1..3 follow at 11, 12 and 13
`define ZX_HI_PAGE0     8'h10

// classic 128K paging port, full 16 bit decode
`define ZX_PORT_7FFD    16'h7FFD

//////////////////////////////////////////////////////////////////////
// frame timing
//////////////////////////////////////////////////////////////////////

// fclk cycles per frame, short for simulation
`define ZX_FRAME_CYCLES 512

// interrupt pulse width in fclk cycles
`define ZX_INT_LEN      32

// opcode fetch from this high byte enters DOS ROM
`define ZX_DOS_TRAP_HI  8'h3D

`endif

/* source/zx_pkg.sv */
package zx_pkg;

	//////////////////////////////////////////////////////////////////////
	// z80 side
	//////////////////////////////////////////////////////////////////////

	// cpu address and data bus
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	//////////////////////////////////////////////////////////////////////
	// memory map
	//////////////////////////////////////////////////////////////////////

	// physical 16K page number
	typedef logic [7:0] mem_page_t;

	// one of the four 16K windows, taken from a[15:14]
	typedef logic [1:0] win_t;

	// frame position in fclk cycles
	typedef logic [15:0] frame_cnt_t;

	// recognized bus cycle
	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_IO_RD,
		BUS_IO_WR,
		BUS_FETCH,
		BUS_INTACK,
		// wait for all strobes to go inactive
		BUS_HOLD
	} bus_cycle_e;

endpackage

/* source/z_bus_if.sv */
interface z_bus_if;
	import zx_pkg::*;

	// address and write data, already in the fclk domain
	zaddr_t addr;
	zdata_t wdata;

	// one cycle strobes
	logic io_wr_s;
	logic fetch_s;
	logic intack_s;

	// level for the whole recognized port read
	logic io_rd;

	modport ctrl (
		output addr, wdata, io_wr_s, io_rd, fetch_s, intack_s
	);

	// port decoder side
	modport regs (
		input addr, wdata, io_wr_s, io_rd
	);

	// pager and interrupt side
	modport cpu (
		input addr, fetch_s, intack_s
	);

endinterface

/* source/z_bus_ctrl.sv */
module z_bus_ctrl (
	input  logic            fclk,
	input  logic            arst_n,
	input  zx_pkg::zaddr_t  a,
	input  zx_pkg::zdata_t  d_in,
	input  logic            iorq_n,
	input  logic            mreq_n,
	input  logic            m1_n,
	input  logic            rd_n,
	input  logic            wr_n,
	z_bus_if.ctrl           bus
);
	import zx_pkg::*;

	// strobe order is iorq, mreq, m1, rd, wr
	logic [4:0] strb_meta;
	logic [4:0] strb_sync;
	zaddr_t     a_meta;
	zaddr_t     addr_q;
	zdata_t     d_meta;
	zdata_t     wdata_q;
	logic       iorq, mreq, m1, rd, wr;
	bus_cycle_e state, state_nxt;

	//////////////////////////////////////////////////////////////////////
	// two flop synchronizer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			strb_meta <= '1;
			strb_sync <= '1;
		end else begin
			strb_meta <= {iorq_n, mreq_n, m1_n, rd_n, wr_n};
			strb_sync <= strb_meta;
		end
	end

	// address and data take the same two stages so they line up
	always_ff @(posedge fclk) begin
		a_meta  <= a;
		addr_q  <= a_meta;
		d_meta  <= d_in;
		wdata_q <= d_meta;
	end

	assign iorq = !strb_sync[4];
	assign mreq = !strb_sync[3];
	assign m1   = !strb_sync[2];
	assign rd   = !strb_sync[1];
	assign wr   = !strb_sync[0];

	//////////////////////////////////////////////////////////////////////
	// bus cycle fsm
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			BUS_IDLE: begin
				// intack first, it is the only iorq cycle with m1 low
				if (iorq && m1)
					state_nxt = BUS_INTACK;
				else if (iorq && wr)
					state_nxt = BUS_IO_WR;
				else if (iorq && rd)
					state_nxt = BUS_IO_RD;
				else if (mreq && m1 && rd)
					state_nxt = BUS_FETCH;
			end
			// port read lasts as long as rd
			BUS_IO_RD: if (!rd) state_nxt = BUS_HOLD;
			BUS_IO_WR,
			BUS_FETCH,
			BUS_INTACK: state_nxt = BUS_HOLD;
			BUS_HOLD: if (&strb_sync) state_nxt = BUS_IDLE;
			default: state_nxt = BUS_IDLE;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			state <= BUS_IDLE;
		else
			state <= state_nxt;
	end

	assign bus.addr     = addr_q;
	assign bus.wdata    = wdata_q;
	assign bus.io_wr_s  = state == BUS_IO_WR;
	assign bus.io_rd    = state == BUS_IO_RD;
	assign bus.fetch_s  = state == BUS_FETCH;
	assign bus.intack_s = state == BUS_INTACK;

endmodule

/* source/port_regs.sv */
`include "zx_defines.svh"

module port_regs (
	input  logic                     fclk,
	input  logic                     arst_n,
	z_bus_if.regs                    bus,
	output zx_pkg::zdata_t           d_out,
	output logic                     d_oe,
	output zx_pkg::zdata_t           memconf,
	output zx_pkg::mem_page_t [3:0]  win_pages,
	output logic [2:0]               border,
	output logic                     beep
);
	import zx_pkg::*;

	zdata_t hi;
	logic   xt_sel;
	logic   page_hit;
	win_t   page_idx;
	logic   hit_7ffd;
	logic   even_port;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	assign hi     = bus.addr[15:8];
	assign xt_sel = bus.addr[7:0] == `ZX_PORT_XT_LO;

	// four page ports in a row, low two bits pick the window
	assign page_hit = xt_sel && ((hi & 8'hFC) == `ZX_HI_PAGE0);
	assign page_idx = bus.addr[9:8];

	assign hit_7ffd  = bus.addr == `ZX_PORT_7FFD;
	assign even_port = !bus.addr[0];

	//////////////////////////////////////////////////////////////////////
	// writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			memconf   <= '0;
			win_pages <= '0;
			border    <= '0;
			beep      <= 1'b0;
		end else if (bus.io_wr_s) begin
			if (xt_sel) begin
				case (hi)
					`ZX_HI_MEMCONF: memconf <= bus.wdata;
					`ZX_HI_BORDER:  border  <= bus.wdata[2:0];
					// turbo and AY clock bits, nothing here uses them
					`ZX_HI_SYSCONF: ;
					default: begin
						if (page_hit)
							win_pages[page_idx] <= bus.wdata;
					end
				endcase
			end

			// 128K compatible paging, bank into window 3 and ROM select
			if (hit_7ffd) begin
				win_pages[3] <= {5'b0, bus.wdata[2:0]};
				memconf[0]   <= bus.wdata[4];
			end

			// ula port, any even address
			if (even_port) begin
				border <= bus.wdata[2:0];
				beep   <= bus.wdata[4];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		d_oe  = 1'b0;
		d_out = 8'hFF;
		if (bus.io_rd && xt_sel) begin
			if (hi == `ZX_HI_MEMCONF) begin
				d_oe  = 1'b1;
				d_out = memconf;
			end else if (page_hit) begin
				d_oe  = 1'b1;
				d_out = win_pages[page_idx];
			end
		end
	end

endmodule

/* source/mem_pager.sv */
`include "zx_defines.svh"

module mem_pager (
	input  logic                     fclk,
	input  logic                     arst_n,
	z_bus_if.cpu                     bus,
	input  zx_pkg::zaddr_t           a,
	input  zx_pkg::zdata_t           memconf,
	input  zx_pkg::mem_page_t [3:0]  win_pages,
	output zx_pkg::mem_page_t        mem_page,
	output logic                     romnram,
	output logic                     mem_we_en
);
	import zx_pkg::*;

	win_t win;
	win_t fetch_win;
	logic rom_win;
	logic trap_hit;
	logic dos;

	// memconf bit 3 maps RAM over window 0
	assign win     = a[15:14];
	assign rom_win = (win == 2'd0) && !memconf[3];

	//////////////////////////////////////////////////////////////////////
	// window translation
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (rom_win) begin
			// rom page, bit 1 selects DOS, bit 0 is the 128/48 choice
			mem_page  = {win_pages[0][7:2], !dos, memconf[0]};
			romnram   = 1'b1;
			mem_we_en = memconf[1];
		end else begin
			mem_page  = win_pages[win];
			romnram   = 1'b0;
			mem_we_en = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// dos flag
	//////////////////////////////////////////////////////////////////////

	assign fetch_win = bus.addr[15:14];

	// trap only while the 48K basic rom is mapped in window 0
	assign trap_hit = (bus.addr[15:8] == `ZX_DOS_TRAP_HI) && (fetch_win == 2'd0) &&
		!memconf[3] && memconf[0];

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			dos <= 1'b0;
		else if (bus.fetch_s) begin
			if (trap_hit)
				dos <= 1'b1;
			else if (fetch_win != 2'd0)
				dos <= 1'b0;
		end
	end

endmodule

/* source/int_gen.sv */
`include "zx_defines.svh"

module int_gen (
	input  logic  fclk,
	input  logic  arst_n,
	z_bus_if.cpu  bus,
	output logic  int_n
);
	import zx_pkg::*;

	frame_cnt_t frame_cnt;
	frame_cnt_t pulse_cnt;
	logic       frame_end;
	logic       pulse_end;
	logic       int_act;

	assign frame_end = frame_cnt == frame_cnt_t'(`ZX_FRAME_CYCLES - 1);
	assign pulse_end = pulse_cnt == frame_cnt_t'(`ZX_INT_LEN - 1);

	//////////////////////////////////////////////////////////////////////
	// frame counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			frame_cnt <= '0;
		else if (frame_end)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	// pulse starts with the wrap, so never right out of reset
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			int_act   <= 1'b0;
			pulse_cnt <= '0;
		end else if (frame_end) begin
			int_act   <= 1'b1;
			pulse_cnt <= '0;
		end else if (int_act) begin
			pulse_cnt <= pulse_cnt + 1'b1;
			// acknowledge cuts the pulse short
			if (pulse_end || bus.intack_s)
				int_act <= 1'b0;
		end
	end

	assign int_n = !int_act;

endmodule

/* source/zx_core.sv */
module zx_core (
	input  logic               fclk,
	input  logic               arst_n,

	// z80 bus
	input  zx_pkg::zaddr_t     a,
	input  zx_pkg::zdata_t     d_in,
	output zx_pkg::zdata_t     d_out,
	output logic               d_oe,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               m1_n,
	input  logic               rd_n,
	input  logic               wr_n,
	output logic               int_n,

	// memory select
	output zx_pkg::mem_page_t  mem_page,
	output logic               romnram,
	output logic               mem_we_en,

	// ula side
	output logic [2:0]         border,
	output logic               beep
);
	import zx_pkg::*;

	zdata_t          memconf;
	mem_page_t [3:0] win_pages;

	z_bus_if bus ();

	//////////////////////////////////////////////////////////////////////
	// bus cycle recognition
	//////////////////////////////////////////////////////////////////////

	z_bus_ctrl u_z_bus_ctrl (
		.fclk   (fclk),
		.arst_n (arst_n),
		.a      (a),
		.d_in   (d_in),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.m1_n   (m1_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.bus    (bus.ctrl)
	);

	port_regs u_port_regs (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.bus       (bus.regs),
		.d_out     (d_out),
		.d_oe      (d_oe),
		.memconf   (memconf),
		.win_pages (win_pages),
		.border    (border),
		.beep      (beep)
	);

	// raw address, translation has no latency
	mem_pager u_mem_pager (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.bus       (bus.cpu),
		.a         (a),
		.memconf   (memconf),
		.win_pages (win_pages),
		.mem_page  (mem_page),
		.romnram   (romnram),
		.mem_we_en (mem_we_en)
	);

	int_gen u_int_gen (
		.fclk   (fclk),
		.arst_n (arst_n),
		.bus    (bus.cpu),
		.int_n  (int_n)
	);

endmodule

/* bench/zx_core_asserts.sv */
`include "zx_defines.svh"

module zx_core_asserts (
	input  logic            fclk,
	input  logic            arst_n,
	input  zx_pkg::zaddr_t  a,
	input  logic            rd_n,
	input  logic            d_oe,
	input  logic            romnram,
	input  logic            int_n
);

	int err_cnt = 0;
	int low_run;

	// samples of int_n low in the current pulse
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			low_run <= 0;
		else if (int_n)
			low_run <= 0;
		else
			low_run <= low_run + 1;
	end

	a_int_len: assert property (@(posedge fclk) disable iff (!arst_n)
		int_n || low_run < `ZX_INT_LEN)
		else begin
			err_cnt++;
			$error("int_n low longer than the interrupt length");
		end

	// rd_n passes two sync flops and the fsm before d_oe
	a_oe_rd: assert property (@(posedge fclk) disable iff (!arst_n)
		d_oe |-> (!$past(rd_n, 2) || !$past(rd_n, 3) || !$past(rd_n, 4)))
		else begin
			err_cnt++;
			$error("d_oe high without a preceding rd_n low");
		end

	a_rom_win: assert property (@(posedge fclk) disable iff (!arst_n)
		romnram |-> a[15:14] == 2'b00)
		else begin
			err_cnt++;
			$error("romnram high outside window 0");
		end

endmodule

bind zx_core zx_core_asserts u_zx_core_asserts (
	.fclk    (fclk),
	.arst_n  (arst_n),
	.a       (a),
	.rd_n    (rd_n),
	.d_oe    (d_oe),
	.romnram (romnram),
	.int_n   (int_n)
);

/* bench/tb_zx_core.sv */
`include "zx_defines.svh"

module tb_zx_core;
	import zx_pkg::*;

	localparam int BUS_TASKS  = 60;
	localparam int ADDR_STEPS = 128;
	localparam int DRIVE_DLY  = 10;
	// bus tasks of 9 cycles, idle address steps, four frames and two more as margin
	localparam int WATCHDOG_T = (BUS_TASKS * 9 + ADDR_STEPS + 6 * `ZX_FRAME_CYCLES) * 100;

	logic       fclk;
	logic       arst_n;
	zaddr_t     a;
	zdata_t     d_in;
	zdata_t     d_out;
	logic       d_oe;
	logic       iorq_n, mreq_n, m1_n, rd_n, wr_n;
	logic       int_n;
	mem_page_t  mem_page;
	logic       romnram, mem_we_en, beep;
	logic [2:0] border;

	// shadow state of the reference model
	zdata_t     sh_memconf;
	mem_page_t  sh_pages [4];
	logic [2:0] sh_border;
	logic       sh_beep;
	logic       sh_dos;
	logic       bus_busy;

	// int_n edges in fclk cycles since reset release
	int   cyc = 0;
	logic int_prev = 1'b1;
	int   fall_q [$];
	int   rise_q [$];

	zx_core u_zx_core (.*);

	initial fclk = 1'b0;
	always #50 fclk = ~fclk;

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input zdata_t exp, input zdata_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_page(input string name, input mem_page_t exp, input mem_page_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic zdata_t rand_data();
		return zdata_t'($urandom());
	endfunction

	function automatic zaddr_t xt_port(input zdata_t hi);
		return {hi, `ZX_PORT_XT_LO};
	endfunction

	function automatic void model_write(input zaddr_t addr, input zdata_t data);
		zdata_t hi;
		hi = addr[15:8];
		if (addr[7:0] == `ZX_PORT_XT_LO) begin
			if (hi == `ZX_HI_MEMCONF)
				sh_memconf = data;
			else if (hi == `ZX_HI_BORDER)
				sh_border = data[2:0];
			else if (hi >= `ZX_HI_PAGE0 && hi <= `ZX_HI_PAGE0 + 8'd3)
				sh_pages[win_t'(hi - `ZX_HI_PAGE0)] = data;
		end
		if (addr == `ZX_PORT_7FFD) begin
			sh_pages[3]   = {5'b0, data[2:0]};
			sh_memconf[0] = data[4];
		end
		if (!addr[0]) begin
			sh_border = data[2:0];
			sh_beep   = data[4];
		end
	endfunction

	function automatic void model_fetch(input zaddr_t addr);
		if (addr[15:8] == `ZX_DOS_TRAP_HI && !sh_memconf[3] && sh_memconf[0])
			sh_dos = 1'b1;
		else if (addr[15:14] != 2'd0)
			sh_dos = 1'b0;
	endfunction

	// expected {mem_page, romnram, mem_we_en}
	function automatic logic [9:0] calc_page(input zaddr_t addr);
		mem_page_t page;
		logic      rom;
		logic      we;
		if (addr[15:14] == 2'd0 && !sh_memconf[3]) begin
			page = {sh_pages[0][7:2], !sh_dos, sh_memconf[0]};
			rom  = 1'b1;
			we   = sh_memconf[1];
		end else begin
			page = sh_pages[addr[15:14]];
			rom  = 1'b0;
			we   = 1'b1;
		end
		return {page, rom, we};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// z80 cycles
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge fclk);
		#DRIVE_DLY;
	endtask

	// strobe order iorq, mreq, m1, rd, wr; bus sampled in the 5th low cycle
	task automatic run_cycle(input zaddr_t addr, input zdata_t data, input logic [4:0] strb,
			output zdata_t rdata, output logic roe);
		bus_busy = 1'b1;
		a        = addr;
		d_in     = data;
		{iorq_n, mreq_n, m1_n, rd_n, wr_n} = strb;
		repeat (5) step();
		@(negedge fclk);
		rdata = d_out;
		roe   = d_oe;
		step();
		{iorq_n, mreq_n, m1_n, rd_n, wr_n} = 5'b11111;
		repeat (3) step();
	endtask

	task automatic io_write(input zaddr_t addr, input zdata_t data);
		zdata_t rdata;
		logic   roe;
		run_cycle(addr, data, 5'b01110, rdata, roe);
		model_write(addr, data);
		bus_busy = 1'b0;
	endtask

	task automatic io_read(input zaddr_t addr, output zdata_t data, output logic oe);
		run_cycle(addr, 8'h00, 5'b01101, data, oe);
		bus_busy = 1'b0;
	endtask

	task automatic fetch(input zaddr_t addr);
		zdata_t rdata;
		logic   roe;
		run_cycle(addr, 8'h00, 5'b10001, rdata, roe);
		model_fetch(addr);
		bus_busy = 1'b0;
	endtask

	task automatic intack();
		zdata_t rdata;
		logic   roe;
		run_cycle(a, 8'h00, 5'b01011, rdata, roe);
		bus_busy = 1'b0;
	endtask

	// bit 1 of the rom page is the inverted dos flag
	task automatic dos_page_bit(input string name, input logic exp);
		a = 16'h0123;
		@(negedge fclk);
		check_bit(name, exp, mem_page[1]);
		step();
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking and monitoring
	//////////////////////////////////////////////////////////////////////

	always @(negedge fclk) begin : compare_outputs
		logic [9:0] exp;
		if (arst_n && !bus_busy) begin
			exp = calc_page(a);
			check_page("page map", exp[9:2], mem_page);
			check_bit("rom select", exp[1], romnram);
			check_bit("write enable", exp[0], mem_we_en);
			check_data("border", {5'b0, sh_border}, {5'b0, border});
			check_bit("beep", sh_beep, beep);
		end
	end

	always @(negedge fclk) begin
		if (arst_n) begin
			if (int_prev && !int_n)
				fall_q.push_back(cyc);
			if (!int_prev && int_n)
				rise_q.push_back(cyc);
			int_prev = int_n;
			cyc++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_T);
		$display("timeout: the run did not finish in the expected time");
		abort_run();
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		zdata_t data;
		zdata_t rdata;
		logic   roe;
		int     idx;
		void'($urandom(32'h1c5a));
		arst_n   = 1'b0;
		a        = '0;
		d_in     = '0;
		{iorq_n, mreq_n, m1_n, rd_n, wr_n} = 5'b11111;
		bus_busy = 1'b1;
		sh_memconf = '0;
		sh_pages   = '{default: '0};
		sh_border  = '0;
		sh_beep    = 1'b0;
		sh_dos     = 1'b0;
		repeat (4) @(posedge fclk);
		#DRIVE_DLY;
		arst_n   = 1'b1;
		bus_busy = 1'b0;

		// register writes and readback
		repeat (2) begin
			for (int w = 0; w < 4; w++)
				io_write(xt_port(`ZX_HI_PAGE0 + zdata_t'(w)), rand_data());
			io_write(xt_port(`ZX_HI_MEMCONF), rand_data());
			io_write(`ZX_PORT_7FFD, rand_data());
			io_read(xt_port(`ZX_HI_MEMCONF), rdata, roe);
			check_bit("memconf read enable", 1'b1, roe);
			check_data("memconf read", sh_memconf, rdata);
			for (int w = 0; w < 4; w++) begin
				io_read(xt_port(`ZX_HI_PAGE0 + zdata_t'(w)), rdata, roe);
				check_bit("page read enable", 1'b1, roe);
				check_page("page read", sh_pages[w], rdata);
			end
			io_read(xt_port(`ZX_HI_SYSCONF), rdata, roe);
			check_bit("undecoded read enable", 1'b0, roe);
		end

		// random memconf, the address checks run in compare_outputs
		for (int i = 0; i < 8; i++) begin
			io_write(xt_port(`ZX_HI_MEMCONF), rand_data());
			io_write(xt_port(`ZX_HI_PAGE0 + zdata_t'(i % 4)), rand_data());
			repeat (ADDR_STEPS / 8) begin
				a = zaddr_t'($urandom());
				step();
			end
		end

		// dos trap
		io_write(xt_port(`ZX_HI_MEMCONF), 8'h01);
		fetch(16'h3D2F);
		dos_page_bit("dos set by trap fetch", 1'b0);
		fetch(16'h4000 | (zaddr_t'($urandom()) & 16'h3FFF));
		dos_page_bit("dos cleared by window 1 fetch", 1'b1);
		io_write(xt_port(`ZX_HI_MEMCONF), 8'h00);
		fetch(16'h3D00);
		dos_page_bit("no trap with 128 rom", 1'b1);

		// ula port, even sets and odd leaves alone
		for (int i = 0; i < 4; i++) begin
			data = rand_data();
			io_write({rand_data(), rand_data() & 8'hFE}, data);
			io_write({rand_data(), 8'hFB}, rand_data());
			@(negedge fclk);
			check_data("border after odd port", {5'b0, data[2:0]}, {5'b0, border});
			check_bit("beep after odd port", data[4], beep);
			step();
		end

		// frame interrupt
		while (fall_q.size() < 3)
			step();
		check_count("first int fall", `ZX_FRAME_CYCLES, fall_q[0]);
		for (int i = 1; i < fall_q.size(); i++)
			check_count("int period", `ZX_FRAME_CYCLES, fall_q[i] - fall_q[i-1]);
		for (int i = 0; i < rise_q.size(); i++)
			check_count("int width", `ZX_INT_LEN, rise_q[i] - fall_q[i]);

		while (int_n)
			step();
		intack();
		idx = fall_q.size() - 1;
		check_count("int released by intack", fall_q.size(), rise_q.size());
		check_bit("intack shortens pulse", 1'b1, rise_q[idx] - fall_q[idx] < `ZX_INT_LEN);
		while (fall_q.size() < idx + 2)
			step();
		check_count("int period after intack", `ZX_FRAME_CYCLES, fall_q[idx+1] - fall_q[idx]);

		if (u_zx_core.u_zx_core_asserts.err_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("the bound assertion checker reported failures");
			abort_run();
		end
	end

endmodule

/* verilog.f */
+incdir+include
source/zx_pkg.sv
source/z_bus_if.sv
source/z_bus_ctrl.sv
source/port_regs.sv
source/mem_pager.sv
source/int_gen.sv
source/zx_core.sv
bench/zx_core_asserts.sv
bench/tb_zx_core.sv

/* Bender.yml */
package:
  name: zx_core

sources:
  - include_dirs:
      - include
    files:
      - source/zx_pkg.sv
      - source/z_bus_if.sv
      - source/z_bus_ctrl.sv
      - source/port_regs.sv
      - source/mem_pager.sv
      - source/int_gen.sv
      - source/zx_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/zx_core_asserts.sv
      - bench/tb_zx_core.sv
